// ==== executeStage.f ====
+incdir+src
+incdir+tb
src/mipsExecPkg.sv
src/aluControl.sv
src/alu32Bit.sv
src/hiLoUnit.sv
src/executeStage.sv
tb/executeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module executeStageTb \
    -f executeStage.f \
    -Mdir obj_dir \
    -o simExecuteStage

./obj_dir/simExecuteStage > sim.log 2>&1
cat sim.log

if grep -qF '** FAIL **' sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

// ==== src/alu32Bit.sv ====
`include "mipsExec_config.svh"

module alu32Bit import mipsExecPkg::*; (
    input  aluOpT              aluOp,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  logic [`DATA_W-1:0] hi,
    input  logic [`DATA_W-1:0] lo,
    output logic [`DATA_W-1:0] result,
    output logic               condition,
    output logic               writeEnable
);

    localparam int HALF_W = `DATA_W / 2;

    logic [`SHAMT_W-1:0]         shamt;      // a[4:0]
    logic [2*`DATA_W-1:0]        rotWide;    // b doubled for rotate
    logic signed [2*`DATA_W-1:0] product;    // full signed product
    logic                        aNeg;       // sign of a
    logic                        aZero;

    assign shamt   = a[`SHAMT_W-1:0];
    assign rotWide = {b, b} >> shamt;         // low word is the rotated value
    assign product = $signed(a) * $signed(b);
    assign aNeg    = a[`DATA_W-1];
    assign aZero   = (a == '0);

    //////////////////////////////
    // operation select
    //////////////////////////////

    always_comb begin
        result      = '0;
        condition   = 1'b0;
        writeEnable = 1'b1;   // most ops write rd/rt
        case (aluOp)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluNor:  result = ~(a | b);
            aluXor:  result = a ^ b;
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;
            aluSra:  result = $signed(b) >>> shamt;   // sign fill
            aluRotr: result = rotWide[`DATA_W-1:0];
            aluSlt:  result = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu: result = {{(`DATA_W-1){1'b0}}, a < b};
            aluLui:  result = b << HALF_W;
            aluSeb:  result = {{(`DATA_W-8){b[7]}}, b[7:0]};
            aluSeh:  result = {{(`DATA_W-16){b[15]}}, b[15:0]};
            aluMovn: begin
                result      = a;
                writeEnable = (b != '0);   // write only if rt nonzero
            end
            aluMovz: begin
                result      = a;
                writeEnable = (b == '0);
            end
            aluMul:  result = product[`DATA_W-1:0];   // low word only
            aluMfhi: result = hi;
            aluMflo: result = lo;

            // branches leave result at zero
            aluBeq: begin
                writeEnable = 1'b0;
                condition   = (a == b);
            end
            aluBne: begin
                writeEnable = 1'b0;
                condition   = (a != b);
            end
            aluBgez: begin
                writeEnable = 1'b0;
                condition   = !aNeg;
            end
            aluBltz: begin
                writeEnable = 1'b0;
                condition   = aNeg;
            end
            aluBgtz: begin
                writeEnable = 1'b0;
                condition   = !aNeg && !aZero;
            end
            aluBlez: begin
                writeEnable = 1'b0;
                condition   = aNeg || aZero;
            end
            default: writeEnable = 1'b0;   // aluNone, also mult and mthi/mtlo
        endcase
    end

    // a taken branch never writes a register
    always_comb begin
        assert final (!(condition && writeEnable))
            else $error("branch condition with write enable, op %s", aluOp.name());
    end

endmodule

// ==== src/aluControl.sv ====
`include "mipsExec_config.svh"

module aluControl import mipsExecPkg::*; (
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic [`RT_W-1:0]     rtField,
    output aluOpT                aluOp,
    output hiLoOpT               hiLoOp
);

    always_comb begin
        aluOp  = aluNone;   // jumps, jr, unknown
        hiLoOp = hiLoNone;
        case (opcode)
            //////////////////////////////
            // r-type
            //////////////////////////////
            opSpecial: begin
                case (funct)
                    fnAdd, fnAddu:    aluOp = aluAdd;
                    fnSub, fnSubu:    aluOp = aluSub;
                    fnAnd:            aluOp = aluAnd;
                    fnOr:             aluOp = aluOr;
                    fnNor:            aluOp = aluNor;
                    fnXor:            aluOp = aluXor;
                    fnSll, fnSllv:    aluOp = aluSll;   // amount always on A
                    fnSrl:            aluOp = aluSrl;
                    fnSra, fnSrav:    aluOp = aluSra;
                    fnRotr:           aluOp = aluRotr;
                    fnSlt:            aluOp = aluSlt;
                    fnSltu:           aluOp = aluSltu;
                    fnMovn:           aluOp = aluMovn;
                    fnMovz:           aluOp = aluMovz;
                    fnMfhi:           aluOp = aluMfhi;
                    fnMflo:           aluOp = aluMflo;
                    fnMult, fnMultu:  hiLoOp = hiLoMult;  // no unsigned variant
                    fnMthi:           hiLoOp = hiLoMthi;
                    fnMtlo:           hiLoOp = hiLoMtlo;
                    default:          aluOp = aluNone;  // jr lands here
                endcase
            end
            opSpecial2: begin
                case (funct)
                    fnMul:   aluOp = aluMul;
                    fnMadd:  hiLoOp = hiLoMadd;
                    fnMsub:  hiLoOp = hiLoMsub;
                    default: aluOp = aluNone;
                endcase
            end
            opSpecial3: begin
                case (funct)
                    fnSeb:   aluOp = aluSeb;
                    fnSeh:   aluOp = aluSeh;
                    default: aluOp = aluNone;
                endcase
            end
            opRegimm: begin
                case (rtField)
                    rtBgez:  aluOp = aluBgez;
                    rtBltz:  aluOp = aluBltz;
                    default: aluOp = aluNone;
                endcase
            end

            //////////////////////////////
            // i-type and memory
            //////////////////////////////
            opAddi, opAddiu:      aluOp = aluAdd;
            opAndi:               aluOp = aluAnd;
            opOri:                aluOp = aluOr;
            opXori:               aluOp = aluXor;
            opSlti:               aluOp = aluSlt;
            opSltiu:              aluOp = aluSltu;
            opLui:                aluOp = aluLui;
            opLw, opLh, opLb,
            opSw, opSh, opSb:     aluOp = aluAdd;   // address sum
            opBeq:                aluOp = aluBeq;
            opBne:                aluOp = aluBne;
            opBgtz:               aluOp = aluBgtz;
            opBlez:               aluOp = aluBlez;
            default:              aluOp = aluNone;
        endcase
    end

    // hi/lo is only touched from the two r-type groups
    always_comb begin
        if (opcode != opSpecial && opcode != opSpecial2) begin
            assert final (hiLoOp == hiLoNone)
                else $error("hiLoOp %s decoded outside special groups", hiLoOp.name());
        end
    end

endmodule

// ==== src/executeStage.sv ====
`include "mipsExec_config.svh"

module executeStage import mipsExecPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 inValid,
    input  logic [`OPCODE_W-1:0] opcode,
    input  logic [`FUNCT_W-1:0]  funct,
    input  logic [`RT_W-1:0]     rtField,
    input  logic [`DATA_W-1:0]   operandA,
    input  logic [`DATA_W-1:0]   operandB,
    output logic                 outValid,
    output logic [`DATA_W-1:0]   aluResult,
    output logic                 branchTaken,
    output logic                 regWrite
);

    aluOpT              aluOp;
    hiLoOpT             hiLoOp;
    logic [`DATA_W-1:0] hi;
    logic [`DATA_W-1:0] lo;
    logic [`DATA_W-1:0] result;        // comb alu output
    logic               condition;
    logic               writeEnable;

    //////////////////////////////
    // decode, hi/lo, alu
    //////////////////////////////

    aluControl uAluControl (
        .opcode  (opcode),
        .funct   (funct),
        .rtField (rtField),
        .aluOp   (aluOp),
        .hiLoOp  (hiLoOp)
    );

    hiLoUnit uHiLoUnit (
        .clk    (clk),
        .reset  (reset),
        .update (inValid),   // ops ignored without a valid instr
        .hiLoOp (hiLoOp),
        .a      (operandA),
        .b      (operandB),
        .hi     (hi),
        .lo     (lo)
    );

    alu32Bit uAlu32Bit (
        .aluOp       (aluOp),
        .a           (operandA),
        .b           (operandB),
        .hi          (hi),
        .lo          (lo),
        .result      (result),
        .condition   (condition),
        .writeEnable (writeEnable)
    );

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid    <= 1'b0;
            aluResult   <= '0;
            branchTaken <= 1'b0;
            regWrite    <= 1'b0;
        end else begin
            outValid    <= inValid;
            branchTaken <= inValid & condition;     // no flag without valid
            regWrite    <= inValid & writeEnable;
            if (inValid) begin
                aluResult <= result;                // held while idle
            end
        end
    end

    // one-cycle latency, nothing left over after an idle input
    assert property (@(posedge clk) disable iff (reset) !inValid |=> !outValid)
        else $error("outValid high after idle inValid");

endmodule

// ==== src/hiLoUnit.sv ====
`include "mipsExec_config.svh"

module hiLoUnit import mipsExecPkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               update,
    input  hiLoOpT             hiLoOp,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo
);

    logic [2*`DATA_W-1:0]        acc;       // {hi, lo}
    logic signed [2*`DATA_W-1:0] product;   // signed a*b, 64 bit

    assign product = $signed(a) * $signed(b);

    assign hi = acc[2*`DATA_W-1:`DATA_W];
    assign lo = acc[`DATA_W-1:0];

    //////////////////////////////
    // accumulator update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (update) begin   // idle cycles hold
            case (hiLoOp)
                hiLoMult: acc <= product;
                hiLoMadd: acc <= acc + product;   // single add of old pair
                hiLoMsub: acc <= acc - product;
                hiLoMthi: acc[2*`DATA_W-1:`DATA_W] <= a;   // lo kept
                hiLoMtlo: acc[`DATA_W-1:0] <= a;           // hi kept
                default:  acc <= acc;
            endcase
        end
    end

    // pair comes out of reset cleared
    assert property (@(posedge clk) reset |=> (hi == '0 && lo == '0))
        else $error("hi/lo not cleared after reset");

endmodule

// ==== src/mipsExecPkg.sv ====
`include "mipsExec_config.svh"

package mipsExecPkg;

    //////////////////////////////
    // operation codes
    //////////////////////////////

    typedef enum logic [4:0] {
        aluNone, aluAdd, aluSub, aluAnd, aluOr, aluNor, aluXor,  // arith and logic
        aluSll, aluSrl, aluSra, aluRotr,                         // shifts
        aluSlt, aluSltu, aluLui, aluSeb, aluSeh,                 // compare and extend
        aluMovn, aluMovz, aluMul,                                // moves, low product
        aluMfhi, aluMflo,                                        // hi/lo readback
        aluBeq, aluBne, aluBgez, aluBltz, aluBgtz, aluBlez       // branch tests
    } aluOpT;

    typedef enum logic [2:0] {
        hiLoNone, hiLoMult, hiLoMadd, hiLoMsub, hiLoMthi, hiLoMtlo
    } hiLoOpT;

    //////////////////////////////
    // opcode field
    //////////////////////////////

    localparam logic [`OPCODE_W-1:0] opSpecial  = 6'b000000;  // r-type
    localparam logic [`OPCODE_W-1:0] opRegimm   = 6'b000001;  // bgez, bltz
    localparam logic [`OPCODE_W-1:0] opBeq      = 6'b000100;
    localparam logic [`OPCODE_W-1:0] opBne      = 6'b000101;
    localparam logic [`OPCODE_W-1:0] opBlez     = 6'b000110;
    localparam logic [`OPCODE_W-1:0] opBgtz     = 6'b000111;
    localparam logic [`OPCODE_W-1:0] opAddi     = 6'b001000;
    localparam logic [`OPCODE_W-1:0] opAddiu    = 6'b001001;
    localparam logic [`OPCODE_W-1:0] opSlti     = 6'b001010;
    localparam logic [`OPCODE_W-1:0] opSltiu    = 6'b001011;
    localparam logic [`OPCODE_W-1:0] opAndi     = 6'b001100;
    localparam logic [`OPCODE_W-1:0] opOri      = 6'b001101;
    localparam logic [`OPCODE_W-1:0] opXori     = 6'b001110;
    localparam logic [`OPCODE_W-1:0] opLui      = 6'b001111;
    localparam logic [`OPCODE_W-1:0] opSpecial2 = 6'b011100;  // mul, madd, msub
    localparam logic [`OPCODE_W-1:0] opSpecial3 = 6'b011111;  // seb, seh
    localparam logic [`OPCODE_W-1:0] opLb       = 6'b100000;
    localparam logic [`OPCODE_W-1:0] opLh       = 6'b100001;
    localparam logic [`OPCODE_W-1:0] opLw       = 6'b100011;
    localparam logic [`OPCODE_W-1:0] opSb       = 6'b101000;
    localparam logic [`OPCODE_W-1:0] opSh       = 6'b101001;
    localparam logic [`OPCODE_W-1:0] opSw       = 6'b101011;

    //////////////////////////////
    // funct field
    //////////////////////////////

    localparam logic [`FUNCT_W-1:0] fnSll   = 6'b000000;
    localparam logic [`FUNCT_W-1:0] fnSrl   = 6'b000010;
    localparam logic [`FUNCT_W-1:0] fnSra   = 6'b000011;
    localparam logic [`FUNCT_W-1:0] fnSllv  = 6'b000100;
    localparam logic [`FUNCT_W-1:0] fnRotr  = 6'b000110;  // R bit not carried, srlv slot
    localparam logic [`FUNCT_W-1:0] fnSrav  = 6'b000111;
    localparam logic [`FUNCT_W-1:0] fnJr    = 6'b001000;
    localparam logic [`FUNCT_W-1:0] fnMovz  = 6'b001010;
    localparam logic [`FUNCT_W-1:0] fnMovn  = 6'b001011;
    localparam logic [`FUNCT_W-1:0] fnMfhi  = 6'b010000;
    localparam logic [`FUNCT_W-1:0] fnMthi  = 6'b010001;
    localparam logic [`FUNCT_W-1:0] fnMflo  = 6'b010010;
    localparam logic [`FUNCT_W-1:0] fnMtlo  = 6'b010011;
    localparam logic [`FUNCT_W-1:0] fnMult  = 6'b011000;
    localparam logic [`FUNCT_W-1:0] fnMultu = 6'b011001;  // treated as mult
    localparam logic [`FUNCT_W-1:0] fnAdd   = 6'b100000;
    localparam logic [`FUNCT_W-1:0] fnAddu  = 6'b100001;
    localparam logic [`FUNCT_W-1:0] fnSub   = 6'b100010;
    localparam logic [`FUNCT_W-1:0] fnSubu  = 6'b100011;
    localparam logic [`FUNCT_W-1:0] fnAnd   = 6'b100100;
    localparam logic [`FUNCT_W-1:0] fnOr    = 6'b100101;
    localparam logic [`FUNCT_W-1:0] fnXor   = 6'b100110;
    localparam logic [`FUNCT_W-1:0] fnNor   = 6'b100111;
    localparam logic [`FUNCT_W-1:0] fnSlt   = 6'b101010;
    localparam logic [`FUNCT_W-1:0] fnSltu  = 6'b101011;

    // special2 group
    localparam logic [`FUNCT_W-1:0] fnMadd  = 6'b000000;
    localparam logic [`FUNCT_W-1:0] fnMul   = 6'b000010;
    localparam logic [`FUNCT_W-1:0] fnMsub  = 6'b000100;

    // special3 bshfl, sa field not carried so seh takes the next slot
    localparam logic [`FUNCT_W-1:0] fnSeb   = 6'b100000;
    localparam logic [`FUNCT_W-1:0] fnSeh   = 6'b100001;

    // regimm rt field
    localparam logic [`RT_W-1:0] rtBltz = 5'b00000;
    localparam logic [`RT_W-1:0] rtBgez = 5'b00001;

endpackage

// ==== src/mipsExec_config.svh ====
`ifndef MIPSEXEC_CONFIG_SVH
`define MIPSEXEC_CONFIG_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define DATA_W   32   // operand and result width

//////////////////////////////
// instruction field widths
//////////////////////////////

`define OPCODE_W 6    // instr[31:26]
`define FUNCT_W  6    // instr[5:0]
`define RT_W     5    // instr[20:16], selects REGIMM branch

// shift and rotate amount comes from operand A, low bits only
`define SHAMT_W  5    // log2 of DATA_W

`endif

// ==== tb/executeStageVectors.svh ====
// hi/lo pair after each accumulate step of the directed sequence
localparam longint accMult = -64'sd3 * 64'sd7;                   // mult
localparam longint accMadd = accMult + 64'sd65536 * 64'sd65536;  // madd adds once
localparam longint accMsub = accMadd - (-64'sd5 * 64'sd100);     // msub

// opcode, funct, rtField, a, b, expected result, branchTaken, regWrite
task automatic loadVectors();
    //////////////////////////////
    // arithmetic and logic
    addRow(opSpecial, fnAdd, 5'd0, 32'h00000007, 32'h00000005, 32'h0000000c, 1'b0, 1'b1);
    addRow(opSpecial, fnAddu, 5'd0, 32'hffffffff, 32'h00000002, 32'h00000001, 1'b0, 1'b1);
    addRow(opSpecial, fnSub, 5'd0, 32'h00000005, 32'h00000007, 32'hfffffffe, 1'b0, 1'b1);
    addRow(opSpecial, fnAnd, 5'd0, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000, 1'b0, 1'b1);
    addRow(opSpecial, fnOr, 5'd0, 32'hf0f0f0f0, 32'hff00ff00, 32'hfff0fff0, 1'b0, 1'b1);
    addRow(opSpecial, fnNor, 5'd0, 32'hf0f0f0f0, 32'h0f0f0000, 32'h00000f0f, 1'b0, 1'b1);
    addRow(opSpecial, fnXor, 5'd0, 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0, 1'b0, 1'b1);
    // immediates arrive already extended on b
    addRow(opAddi, 6'd0, 5'd0, 32'h00000064, 32'hffffffff, 32'h00000063, 1'b0, 1'b1);
    addRow(opAddiu, 6'd0, 5'd0, 32'h0000000a, 32'h00000014, 32'h0000001e, 1'b0, 1'b1);
    addRow(opAndi, 6'd0, 5'd0, 32'h12345678, 32'h0000ffff, 32'h00005678, 1'b0, 1'b1);
    addRow(opOri, 6'd0, 5'd0, 32'h12340000, 32'h00005678, 32'h12345678, 1'b0, 1'b1);
    addRow(opXori, 6'd0, 5'd0, 32'h0000ffff, 32'h00000f0f, 32'h0000f0f0, 1'b0, 1'b1);
    addRow(opSlti, 6'd0, 5'd0, 32'hffffffff, 32'h00000001, 32'h00000001, 1'b0, 1'b1);
    addRow(opSltiu, 6'd0, 5'd0, 32'hffffffff, 32'h00000001, 32'h00000000, 1'b0, 1'b1);
    // address sums
    addRow(opLw, 6'd0, 5'd0, 32'h00001000, 32'hfffffffc, 32'h00000ffc, 1'b0, 1'b1);
    addRow(opSw, 6'd0, 5'd0, 32'h00002000, 32'h00000008, 32'h00002008, 1'b0, 1'b1);
    addRow(opLb, 6'd0, 5'd0, 32'h00000100, 32'h00000001, 32'h00000101, 1'b0, 1'b1);
    addRow(opLh, 6'd0, 5'd0, 32'h00000100, 32'h00000002, 32'h00000102, 1'b0, 1'b1);
    addRow(opSb, 6'd0, 5'd0, 32'h00000200, 32'hffffffff, 32'h000001ff, 1'b0, 1'b1);
    addRow(opSh, 6'd0, 5'd0, 32'h00000300, 32'h00000004, 32'h00000304, 1'b0, 1'b1);
    // lui, seb and seh with both signs
    addRow(opLui, 6'd0, 5'd0, 32'h00000000, 32'h00001234, 32'h12340000, 1'b0, 1'b1);
    addRow(opLui, 6'd0, 5'd0, 32'h00000000, 32'h0000fedc, 32'hfedc0000, 1'b0, 1'b1);
    addRow(opSpecial3, fnSeb, 5'd0, 32'h0, 32'h00000080, 32'hffffff80, 1'b0, 1'b1);
    addRow(opSpecial3, fnSeb, 5'd0, 32'h0, 32'hffffff7f, 32'h0000007f, 1'b0, 1'b1);
    addRow(opSpecial3, fnSeh, 5'd0, 32'h0, 32'h00008000, 32'hffff8000, 1'b0, 1'b1);
    addRow(opSpecial3, fnSeh, 5'd0, 32'h0, 32'hffff7fff, 32'h00007fff, 1'b0, 1'b1);

    //////////////////////////////
    // shifts with the amount on a
    addRow(opSpecial, fnSll, 5'd0, 32'd0, 32'h80000001, 32'h80000001, 1'b0, 1'b1);
    addRow(opSpecial, fnSll, 5'd0, 32'd1, 32'h80000001, 32'h00000002, 1'b0, 1'b1);
    addRow(opSpecial, fnSll, 5'd0, 32'd31, 32'h80000001, 32'h80000000, 1'b0, 1'b1);
    addRow(opSpecial, fnSrl, 5'd0, 32'd0, 32'h80000001, 32'h80000001, 1'b0, 1'b1);
    addRow(opSpecial, fnSrl, 5'd0, 32'd1, 32'h80000001, 32'h40000000, 1'b0, 1'b1);
    addRow(opSpecial, fnSrl, 5'd0, 32'd31, 32'h80000001, 32'h00000001, 1'b0, 1'b1);
    addRow(opSpecial, fnSra, 5'd0, 32'd0, 32'h80000001, 32'h80000001, 1'b0, 1'b1);
    addRow(opSpecial, fnSra, 5'd0, 32'd1, 32'h80000001, 32'hc0000000, 1'b0, 1'b1);
    addRow(opSpecial, fnSra, 5'd0, 32'd31, 32'h80000001, 32'hffffffff, 1'b0, 1'b1);
    addRow(opSpecial, fnRotr, 5'd0, 32'd0, 32'h80000001, 32'h80000001, 1'b0, 1'b1);
    addRow(opSpecial, fnRotr, 5'd0, 32'd1, 32'h80000001, 32'hc0000000, 1'b0, 1'b1);
    addRow(opSpecial, fnRotr, 5'd0, 32'd31, 32'h80000001, 32'h00000003, 1'b0, 1'b1);
    // set-less-than with mixed signs
    addRow(opSpecial, fnSlt, 5'd0, 32'hfffffffe, 32'h00000003, 32'h1, 1'b0, 1'b1);
    addRow(opSpecial, fnSlt, 5'd0, 32'h00000003, 32'hfffffffe, 32'h0, 1'b0, 1'b1);
    addRow(opSpecial, fnSltu, 5'd0, 32'hfffffffe, 32'h00000003, 32'h0, 1'b0, 1'b1);
    addRow(opSpecial, fnSltu, 5'd0, 32'h00000003, 32'hfffffffe, 32'h1, 1'b0, 1'b1);

    //////////////////////////////
    // branches give a zero result and no write
    addRow(opBeq, 6'd0, 5'd0, 32'h00000005, 32'h00000005, 32'h0, 1'b1, 1'b0);
    addRow(opBeq, 6'd0, 5'd0, 32'h00000005, 32'h00000006, 32'h0, 1'b0, 1'b0);
    addRow(opBne, 6'd0, 5'd0, 32'h00000005, 32'h00000006, 32'h0, 1'b1, 1'b0);
    addRow(opBne, 6'd0, 5'd0, 32'h00000005, 32'h00000005, 32'h0, 1'b0, 1'b0);
    addRow(opRegimm, 6'd0, rtBgez, 32'h00000000, 32'h0, 32'h0, 1'b1, 1'b0);
    addRow(opRegimm, 6'd0, rtBgez, 32'hffffffff, 32'h0, 32'h0, 1'b0, 1'b0);
    addRow(opRegimm, 6'd0, rtBltz, 32'hffffffff, 32'h0, 32'h0, 1'b1, 1'b0);
    addRow(opRegimm, 6'd0, rtBltz, 32'h00000000, 32'h0, 32'h0, 1'b0, 1'b0);
    addRow(opBgtz, 6'd0, 5'd0, 32'h00000001, 32'h0, 32'h0, 1'b1, 1'b0);
    addRow(opBgtz, 6'd0, 5'd0, 32'h00000000, 32'h0, 32'h0, 1'b0, 1'b0);
    addRow(opBgtz, 6'd0, 5'd0, 32'h80000000, 32'h0, 32'h0, 1'b0, 1'b0);
    addRow(opBlez, 6'd0, 5'd0, 32'h00000000, 32'h0, 32'h0, 1'b1, 1'b0);
    addRow(opBlez, 6'd0, 5'd0, 32'hffffffff, 32'h0, 32'h0, 1'b1, 1'b0);
    addRow(opBlez, 6'd0, 5'd0, 32'h00000001, 32'h0, 32'h0, 1'b0, 1'b0);
    addRow(opSpecial, fnJr, 5'd0, 32'h00000040, 32'h0, 32'h0, 1'b0, 1'b0);  // no effect

    //////////////////////////////
    // conditional moves pass a
    addRow(opSpecial, fnMovn, 5'd0, 32'habcd0123, 32'h1, 32'habcd0123, 1'b0, 1'b1);
    addRow(opSpecial, fnMovn, 5'd0, 32'habcd0123, 32'h0, 32'habcd0123, 1'b0, 1'b0);
    addRow(opSpecial, fnMovz, 5'd0, 32'h13572468, 32'h0, 32'h13572468, 1'b0, 1'b1);
    addRow(opSpecial, fnMovz, 5'd0, 32'h13572468, 32'h5, 32'h13572468, 1'b0, 1'b0);

    //////////////////////////////
    // hi/lo sequence where order matters
    addRow(opSpecial, fnMult, 5'd0, 32'hfffffffd, 32'h00000007, 32'h0, 1'b0, 1'b0);
    addRow(opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, accMult[63:32], 1'b0, 1'b1);
    addRow(opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, accMult[31:0], 1'b0, 1'b1);
    addRow(opSpecial2, fnMadd, 5'd0, 32'h00010000, 32'h00010000, 32'h0, 1'b0, 1'b0);
    addRow(opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, accMadd[63:32], 1'b0, 1'b1);
    addRow(opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, accMadd[31:0], 1'b0, 1'b1);
    addRow(opSpecial2, fnMsub, 5'd0, 32'hfffffffb, 32'h00000064, 32'h0, 1'b0, 1'b0);
    addRow(opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, accMsub[63:32], 1'b0, 1'b1);
    addRow(opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, accMsub[31:0], 1'b0, 1'b1);
    addRow(opSpecial, fnMthi, 5'd0, 32'h12345678, 32'h0, 32'h0, 1'b0, 1'b0);
    addRow(opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, 32'h12345678, 1'b0, 1'b1);
    addRow(opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, accMsub[31:0], 1'b0, 1'b1);  // lo kept
    addRow(opSpecial, fnMtlo, 5'd0, 32'h9abcdef0, 32'h0, 32'h0, 1'b0, 1'b0);
    addRow(opSpecial, fnMflo, 5'd0, 32'h0, 32'h0, 32'h9abcdef0, 1'b0, 1'b1);
    addRow(opSpecial, fnMfhi, 5'd0, 32'h0, 32'h0, 32'h12345678, 1'b0, 1'b1);  // hi kept
    addRow(opSpecial2, fnMul, 5'd0, 32'hfffffffd, 32'h00000007, 32'hffffffeb, 1'b0, 1'b1);
endtask

// ==== tb/executeStageTb.sv ====
`include "mipsExec_config.svh"

module executeStageTb import mipsExecPkg::*; ();

    localparam int          timeoutCycles = 10;
    localparam int          burstLen      = 200;
    localparam logic [31:0] randSeed      = 32'h059b01a3;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`FUNCT_W-1:0]  funct;
        logic [`RT_W-1:0]     rt;
        logic [`DATA_W-1:0]   a;
        logic [`DATA_W-1:0]   b;
        logic [`DATA_W-1:0]   res;   // expected aluResult
        logic                 br;    // expected branchTaken
        logic                 wr;    // expected regWrite
    } vecT;

    logic                 clk;
    logic                 reset;
    logic                 inValid;
    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic [`RT_W-1:0]     rtField;
    logic [`DATA_W-1:0]   operandA;
    logic [`DATA_W-1:0]   operandB;
    logic                 outValid;
    logic [`DATA_W-1:0]   aluResult;
    logic                 branchTaken;
    logic                 regWrite;

    vecT         vectors [$];
    int          errors   = 0;
    int          timeouts = 0;

    executeStage DUT (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .opcode      (opcode),
        .funct       (funct),
        .rtField     (rtField),
        .operandA    (operandA),
        .operandB    (operandB),
        .outValid    (outValid),
        .aluResult   (aluResult),
        .branchTaken (branchTaken),
        .regWrite    (regWrite)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // period 20
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic addRow(input logic [`OPCODE_W-1:0] op, input logic [`FUNCT_W-1:0] fn,
                          input logic [`RT_W-1:0] rt, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] res,
                          input logic br, input logic wr);
        vectors.push_back('{op, fn, rt, a, b, res, br, wr});
    endtask

    `include "executeStageVectors.svh"

    task automatic sendRow(input vecT v);
        opcode   = v.opcode;
        funct    = v.funct;
        rtField  = v.rt;
        operandA = v.a;
        operandB = v.b;
        inValid  = 1'b1;   // one-cycle strobe
    endtask

    // first edge captures the row and outValid follows right after it
    task automatic waitOutValid(output logic seen);
        int cycles;
        seen = 1'b0;
        for (cycles = 0; cycles < timeoutCycles && !seen; cycles++) begin
            @(posedge clk);
            #2;
            inValid = 1'b0;
            seen    = outValid;
        end
    endtask

    // back-to-back add/sub/xor with each result one cycle later
    task automatic runBurst();
        logic [31:0] expQ [$];
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] pick;
        int          i;
        for (i = 0; i <= burstLen; i++) begin
            if (i > 0) begin
                checkValue("outValid", 32'd1, 32'(outValid));
                checkValue("aluResult", expQ.pop_front(), aluResult);
                checkValue("regWrite", 32'd1, 32'(regWrite));
            end
            if (i < burstLen) begin
                ra   = $urandom;
                rb   = $urandom;
                pick = $urandom % 3;
                opcode   = opSpecial;
                rtField  = '0;
                operandA = ra;
                operandB = rb;
                inValid  = 1'b1;
                case (pick)
                    32'd0: begin
                        funct = fnAdd;
                        expQ.push_back(ra + rb);
                    end
                    32'd1: begin
                        funct = fnSub;
                        expQ.push_back(ra - rb);
                    end
                    default: begin
                        funct = fnXor;
                        expQ.push_back(ra ^ rb);
                    end
                endcase
            end else begin
                inValid = 1'b0;
            end
            @(posedge clk);
            #2;
        end
        checkValue("outValid", 32'd0, 32'(outValid));   // drained
        checkValue("regWrite", 32'd0, 32'(regWrite));   // last op still on the inputs
        checkValue("branchTaken", 32'd0, 32'(branchTaken));
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        logic seen;
        void'($urandom(randSeed));
        reset     = 1'b1;
        inValid   = 1'b0;
        opcode    = '0;
        funct     = '0;
        rtField   = '0;
        operandA  = '0;
        operandB  = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;

        // idle state after reset
        checkValue("outValid", 32'd0, 32'(outValid));
        checkValue("branchTaken", 32'd0, 32'(branchTaken));
        checkValue("regWrite", 32'd0, 32'(regWrite));
        checkValue("aluResult", 32'd0, aluResult);

        loadVectors();
        foreach (vectors[i]) begin
            sendRow(vectors[i]);
            waitOutValid(seen);
            if (!seen) begin
                $display("timeout: no outValid within %0d cycles for row %0d",
                         timeoutCycles, i);
                timeouts++;
            end else begin
                checkValue("aluResult", vectors[i].res, aluResult);
                checkValue("branchTaken", 32'(vectors[i].br), 32'(branchTaken));
                checkValue("regWrite", 32'(vectors[i].wr), 32'(regWrite));
            end
        end

        runBurst();

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
